// ==== source/commit_trace_pkg.sv ====
// --------------------
// Commit trace package
// Widths, privilege levels, the per-port trace record
// and the retirement counter addresses
// --------------------
package commit_trace_pkg;

  // Data and PC width
  localparam int unsigned XLEN      = 64;
  localparam int unsigned CNT_WIDTH = 64;

  typedef logic [XLEN-1:0] pc_t;
  // Top bit set marks an interrupt
  typedef logic [XLEN-1:0] cause_t;
  typedef logic [31:0]     insn_t;

  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'd0,
    PRIV_LVL_S = 2'd1,
    PRIV_LVL_M = 2'd3
  } priv_lvl_t;

  // One retirement per port, 197 bits
  typedef struct packed {
    logic      valid;
    pc_t       iaddr;
    insn_t     insn;
    priv_lvl_t priv;
    logic      exception;
    logic      interrupt;
    cause_t    cause;
    insn_t     tval;
  } trace_rec_t;

  // Counter bank addresses
  typedef enum logic [1:0] {
    CNT_CYCLE     = 2'd0,
    CNT_INSTR     = 2'd1,
    CNT_EXCEPTION = 2'd2,
    CNT_INTERRUPT = 2'd3
  } cnt_sel_t;

endpackage

// ==== source/trace_port_reg.sv ====
// --------------------
// Trace port register
// Classifies one commit port and registers its record
// --------------------
`timescale 1ns/1ps

module trace_port_reg import commit_trace_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       ack_i,
  input  pc_t        pc_i,
  input  logic       ex_valid_i,
  input  cause_t     cause_i,
  input  insn_t      tval_i,
  input  priv_lvl_t  priv_lvl_i,
  output trace_rec_t trace_o
);

  logic      valid_q, exception_q, interrupt_q;
  pc_t       iaddr_q;
  insn_t     tval_q;
  priv_lvl_t priv_q;
  cause_t    cause_q;

  // Classification flags
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q     <= 1'b0;
      exception_q <= 1'b0;
      interrupt_q <= 1'b0;
    end else begin
      valid_q     <= ack_i & ~ex_valid_i;
      exception_q <= ack_i & ex_valid_i & ~cause_i[XLEN-1];
      interrupt_q <= ack_i & ex_valid_i & cause_i[XLEN-1];
    end
  end

  // Record payload, sampled every cycle
  always_ff @(posedge clk_i) begin
    iaddr_q <= pc_i;
    tval_q  <= tval_i;
    priv_q  <= priv_lvl_i;
    cause_q <= cause_i;
  end

  // Trap value doubles as the instruction word
  assign trace_o.valid     = valid_q;
  assign trace_o.iaddr     = iaddr_q;
  assign trace_o.insn      = tval_q;
  assign trace_o.priv      = priv_q;
  assign trace_o.exception = exception_q;
  assign trace_o.interrupt = interrupt_q;
  assign trace_o.cause     = cause_q;
  assign trace_o.tval      = tval_q;

endmodule

// ==== source/pc_fifo.sv ====
// --------------------
// Generic FIFO
// Circular buffer with read and write pointers and a count
// --------------------
`timescale 1ns/1ps

module pc_fifo #(
  parameter type         payload_t = logic [63:0],
  parameter int unsigned Depth     = 16
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     push_i,
  input  payload_t data_i,
  input  logic     pop_i,
  output payload_t data_o,
  output logic     empty_o,
  output logic     full_o
);

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntWidth = $clog2(Depth + 1);

  payload_t              mem_q [Depth];
  logic [PtrWidth-1:0]   rd_ptr_q, wr_ptr_q;
  logic [CntWidth-1:0]   count_q;
  logic                  do_push, do_pop;

  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == CntWidth'(Depth));

  // A push into a full queue is lost
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  assign data_o = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

// ==== source/rr_arbiter.sv ====
// --------------------
// Round-robin arbiter
// Grants one requester per cycle and passes its payload
// --------------------
`timescale 1ns/1ps

module rr_arbiter #(
  parameter int unsigned NumIn     = 2,
  parameter type         payload_t = logic [63:0]
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic [NumIn-1:0]  req_i,
  input  payload_t          data_i [NumIn],
  output logic [NumIn-1:0]  gnt_o,
  output logic              valid_o,
  output payload_t          data_o
);

  localparam int unsigned IdxWidth = (NumIn > 1) ? $clog2(NumIn) : 1;

  logic [IdxWidth-1:0] ptr_q, ptr_d;
  logic [IdxWidth-1:0] gnt_idx;
  logic                found;

  // First request at or after the pointer
  always_comb begin
    int unsigned cand;
    found   = 1'b0;
    gnt_idx = '0;
    gnt_o   = '0;
    for (int unsigned i = 0; i < NumIn; i++) begin
      cand = (32'(ptr_q) + i) % NumIn;
      if (!found && req_i[cand]) begin
        found       = 1'b1;
        gnt_idx     = IdxWidth'(cand);
        gnt_o[cand] = 1'b1;
      end
    end
  end

  assign valid_o = found;
  assign data_o  = data_i[gnt_idx];

  // Pointer moves past the winner
  assign ptr_d = (gnt_idx == IdxWidth'(NumIn - 1)) ? '0 : gnt_idx + 1'b1;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ptr_q <= '0;
    end else if (found) begin
      ptr_q <= ptr_d;
    end
  end

endmodule

// ==== source/retire_counters.sv ====
// --------------------
// Retirement counters
// Cycle, instruction, exception and interrupt counts,
// addressed for read and write
// --------------------
`timescale 1ns/1ps

module retire_counters import commit_trace_pkg::*; #(
  parameter int unsigned NrCommitPorts = 2
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     debug_mode_i,
  input  logic [NrCommitPorts-1:0] commit_ack_i,
  input  logic [NrCommitPorts-1:0] commit_ex_valid_i,
  input  logic [NrCommitPorts-1:0] commit_irq_i,
  input  cnt_sel_t                 sel_i,
  input  logic                     we_i,
  input  logic [CNT_WIDTH-1:0]     wdata_i,
  output logic [CNT_WIDTH-1:0]     rdata_o
);

  logic [CNT_WIDTH-1:0] cnt_q [4];
  logic [CNT_WIDTH-1:0] cnt_d [4];
  logic [CNT_WIDTH-1:0] n_instr, n_exc, n_irq;

  // Events across all commit ports this cycle
  always_comb begin
    n_instr = '0;
    n_exc   = '0;
    n_irq   = '0;
    for (int unsigned i = 0; i < NrCommitPorts; i++) begin
      n_instr = n_instr + CNT_WIDTH'(commit_ack_i[i] & ~commit_ex_valid_i[i]);
      n_exc   = n_exc
              + CNT_WIDTH'(commit_ack_i[i] & commit_ex_valid_i[i] & ~commit_irq_i[i]);
      n_irq   = n_irq
              + CNT_WIDTH'(commit_ack_i[i] & commit_ex_valid_i[i] & commit_irq_i[i]);
    end
  end

  // --------------------
  // Next counter values
  // --------------------
  always_comb begin
    cnt_d = cnt_q;
    // Counting stops in debug mode
    if (!debug_mode_i) begin
      cnt_d[CNT_CYCLE]     = cnt_q[CNT_CYCLE] + 1'b1;
      cnt_d[CNT_INSTR]     = cnt_q[CNT_INSTR] + n_instr;
      cnt_d[CNT_EXCEPTION] = cnt_q[CNT_EXCEPTION] + n_exc;
      cnt_d[CNT_INTERRUPT] = cnt_q[CNT_INTERRUPT] + n_irq;
    end
    // Write beats the increment
    if (we_i) begin
      cnt_d[sel_i] = wdata_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int unsigned i = 0; i < 4; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      cnt_q <= cnt_d;
    end
  end

  assign rdata_o = cnt_q[sel_i];

endmodule

// ==== source/commit_trace_top.sv ====
// --------------------
// Commit trace top level
// Trace records, retired PC stream and retirement counters
// --------------------
`timescale 1ns/1ps

module commit_trace_top import commit_trace_pkg::*; #(
  parameter int unsigned NrCommitPorts = 2,
  parameter int unsigned PcQueueDepth  = 16
) (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  // Commit ports
  input  logic      [NrCommitPorts-1:0]       commit_ack_i,
  input  pc_t       [NrCommitPorts-1:0]       commit_pc_i,
  input  logic      [NrCommitPorts-1:0]       commit_ex_valid_i,
  input  cause_t    [NrCommitPorts-1:0]       commit_cause_i,
  input  insn_t     [NrCommitPorts-1:0]       commit_tval_i,
  input  priv_lvl_t                           priv_lvl_i,
  input  logic                                debug_mode_i,
  // Counter access
  input  cnt_sel_t                            cnt_sel_i,
  input  logic                                cnt_we_i,
  input  logic      [CNT_WIDTH-1:0]           cnt_wdata_i,
  // Observation outputs
  output trace_rec_t [NrCommitPorts-1:0]      trace_o,
  output logic                                pc_valid_o,
  output pc_t                                 pc_o,
  output logic      [CNT_WIDTH-1:0]           cnt_rdata_o
);

  logic [NrCommitPorts-1:0] pc_push;
  logic [NrCommitPorts-1:0] pc_pop;
  logic [NrCommitPorts-1:0] pc_empty;
  logic [NrCommitPorts-1:0] cause_irq;
  pc_t                      pc_data [NrCommitPorts];

  // --------------------
  // Per-port trace and PC queue
  // --------------------
  for (genvar i = 0; i < NrCommitPorts; i++) begin : gen_port
    // Only clean retirements enter the PC stream
    assign pc_push[i]   = commit_ack_i[i] & ~commit_ex_valid_i[i];
    assign cause_irq[i] = commit_cause_i[i][XLEN-1];

    trace_port_reg i_trace_port_reg (
      .clk_i      ( clk_i                ),
      .rst_ni     ( rst_ni               ),
      .ack_i      ( commit_ack_i[i]      ),
      .pc_i       ( commit_pc_i[i]       ),
      .ex_valid_i ( commit_ex_valid_i[i] ),
      .cause_i    ( commit_cause_i[i]    ),
      .tval_i     ( commit_tval_i[i]     ),
      .priv_lvl_i ( priv_lvl_i           ),
      .trace_o    ( trace_o[i]           )
    );

    pc_fifo #(
      .payload_t ( pc_t         ),
      .Depth     ( PcQueueDepth )
    ) i_pc_fifo (
      .clk_i   ( clk_i          ),
      .rst_ni  ( rst_ni         ),
      .push_i  ( pc_push[i]     ),
      .data_i  ( commit_pc_i[i] ),
      .pop_i   ( pc_pop[i]      ),
      .data_o  ( pc_data[i]     ),
      .empty_o ( pc_empty[i]    ),
      .full_o  (                )
    );
  end

  // --------------------
  // Retired PC merge
  // --------------------
  rr_arbiter #(
    .NumIn     ( NrCommitPorts ),
    .payload_t ( pc_t          )
  ) i_rr_arbiter (
    .clk_i   ( clk_i      ),
    .rst_ni  ( rst_ni     ),
    .req_i   ( ~pc_empty  ),
    .data_i  ( pc_data    ),
    .gnt_o   ( pc_pop     ),
    .valid_o ( pc_valid_o ),
    .data_o  ( pc_o       )
  );

  retire_counters #(
    .NrCommitPorts ( NrCommitPorts )
  ) i_retire_counters (
    .clk_i             ( clk_i             ),
    .rst_ni            ( rst_ni            ),
    .debug_mode_i      ( debug_mode_i      ),
    .commit_ack_i      ( commit_ack_i      ),
    .commit_ex_valid_i ( commit_ex_valid_i ),
    .commit_irq_i      ( cause_irq         ),
    .sel_i             ( cnt_sel_i         ),
    .we_i              ( cnt_we_i          ),
    .wdata_i           ( cnt_wdata_i       ),
    .rdata_o           ( cnt_rdata_o       )
  );

endmodule

// ==== include/commit_trace_vectors.svh ====
// --------------------
// Commit trace vectors
// One row per cycle: stimulus for both commit ports and
// the expected class of each port's retirement
// --------------------
`ifndef COMMIT_TRACE_VECTORS_SVH
`define COMMIT_TRACE_VECTORS_SVH

typedef struct packed {
  logic [1:0]  ack;
  logic [1:0]  ex_valid;
  logic [1:0]  irq;
  logic        rand_pc;
  priv_lvl_t   priv;
  logic        debug;
  logic        cnt_we;
  cnt_sel_t    cnt_sel;
  logic [15:0] cnt_wdata;
  logic [1:0]  kind0;
  logic [1:0]  kind1;
} vec_row_t;

// Expected class per port
localparam logic [1:0] KindNone = 2'd0;
localparam logic [1:0] KindRet  = 2'd1;
localparam logic [1:0] KindExc  = 2'd2;
localparam logic [1:0] KindIrq  = 2'd3;

localparam int unsigned NumRows = 22;

// ack, ex_valid, cause top bit (one bit per port), random pc and tval, priv, debug,
// counter we, sel, wdata, expected class of port 0, of port 1
localparam vec_row_t Vectors [NumRows] = '{
  '{2'b00, 2'b00, 2'b00, 1'b0, PRIV_LVL_M, 1'b1, 1'b0, CNT_CYCLE,     16'h0000, 2'd0, 2'd0},
  '{2'b00, 2'b00, 2'b00, 1'b0, PRIV_LVL_M, 1'b1, 1'b0, CNT_INSTR,     16'h0000, 2'd0, 2'd0},
  '{2'b00, 2'b00, 2'b00, 1'b0, PRIV_LVL_M, 1'b1, 1'b0, CNT_EXCEPTION, 16'h0000, 2'd0, 2'd0},
  '{2'b00, 2'b00, 2'b00, 1'b0, PRIV_LVL_M, 1'b1, 1'b0, CNT_INTERRUPT, 16'h0000, 2'd0, 2'd0},
  '{2'b01, 2'b00, 2'b00, 1'b0, PRIV_LVL_U, 1'b0, 1'b0, CNT_INSTR,     16'h0000, 2'd1, 2'd0},
  '{2'b10, 2'b00, 2'b00, 1'b0, PRIV_LVL_S, 1'b0, 1'b0, CNT_INSTR,     16'h0000, 2'd0, 2'd1},
  '{2'b11, 2'b00, 2'b00, 1'b0, PRIV_LVL_M, 1'b0, 1'b0, CNT_INSTR,     16'h0000, 2'd1, 2'd1},
  '{2'b11, 2'b01, 2'b00, 1'b0, PRIV_LVL_S, 1'b0, 1'b0, CNT_EXCEPTION, 16'h0000, 2'd2, 2'd1},
  '{2'b10, 2'b10, 2'b10, 1'b0, PRIV_LVL_U, 1'b0, 1'b0, CNT_INTERRUPT, 16'h0000, 2'd0, 2'd3},
  '{2'b11, 2'b11, 2'b10, 1'b0, PRIV_LVL_M, 1'b0, 1'b0, CNT_INTERRUPT, 16'h0000, 2'd2, 2'd3},
  '{2'b11, 2'b00, 2'b00, 1'b1, PRIV_LVL_U, 1'b0, 1'b0, CNT_INSTR,     16'h0000, 2'd1, 2'd1},
  '{2'b11, 2'b00, 2'b00, 1'b1, PRIV_LVL_S, 1'b0, 1'b0, CNT_CYCLE,     16'h0000, 2'd1, 2'd1},
  // Cause top bit without an exception is a plain retirement
  '{2'b01, 2'b00, 2'b01, 1'b1, PRIV_LVL_M, 1'b0, 1'b0, CNT_INSTR,     16'h0000, 2'd1, 2'd0},
  '{2'b10, 2'b01, 2'b00, 1'b0, PRIV_LVL_U, 1'b0, 1'b0, CNT_EXCEPTION, 16'h0000, 2'd0, 2'd1},
  // Debug mode, counters hold
  '{2'b11, 2'b00, 2'b00, 1'b0, PRIV_LVL_M, 1'b1, 1'b0, CNT_INSTR,     16'h0000, 2'd1, 2'd1},
  '{2'b11, 2'b11, 2'b01, 1'b0, PRIV_LVL_S, 1'b1, 1'b0, CNT_EXCEPTION, 16'h0000, 2'd3, 2'd2},
  // Writes against increments of the same counter
  '{2'b11, 2'b00, 2'b00, 1'b1, PRIV_LVL_M, 1'b0, 1'b1, CNT_INSTR,     16'h0100, 2'd1, 2'd1},
  '{2'b01, 2'b00, 2'b00, 1'b0, PRIV_LVL_M, 1'b0, 1'b0, CNT_INSTR,     16'h0000, 2'd1, 2'd0},
  '{2'b10, 2'b10, 2'b10, 1'b0, PRIV_LVL_S, 1'b0, 1'b1, CNT_INTERRUPT, 16'h0040, 2'd0, 2'd3},
  '{2'b00, 2'b00, 2'b00, 1'b0, PRIV_LVL_U, 1'b0, 1'b1, CNT_CYCLE,     16'h1000, 2'd0, 2'd0},
  '{2'b11, 2'b01, 2'b00, 1'b0, PRIV_LVL_U, 1'b0, 1'b1, CNT_EXCEPTION, 16'h0020, 2'd2, 2'd1},
  '{2'b11, 2'b00, 2'b00, 1'b1, PRIV_LVL_S, 1'b0, 1'b0, CNT_EXCEPTION, 16'h0000, 2'd1, 2'd1}
};

`endif

// ==== verification/commit_trace_tb.sv ====
// --------------------
// Commit trace testbench
// Applies the vector table to the commit ports and checks trace
// records, the retired PC stream and the counters against a model
// --------------------
`timescale 1ns/1ps

module commit_trace_tb import commit_trace_pkg::*; ();

  localparam int unsigned NrPorts      = 2;
  localparam int unsigned DrainTimeout = 100;

  `include "commit_trace_vectors.svh"

  logic                     clk;
  logic                     rst_n;
  logic       [NrPorts-1:0] commit_ack;
  pc_t        [NrPorts-1:0] commit_pc;
  logic       [NrPorts-1:0] commit_ex_valid;
  cause_t     [NrPorts-1:0] commit_cause;
  insn_t      [NrPorts-1:0] commit_tval;
  priv_lvl_t                priv_lvl;
  logic                     debug_mode;
  cnt_sel_t                 cnt_sel;
  logic                     cnt_we;
  logic       [63:0]        cnt_wdata;
  trace_rec_t [NrPorts-1:0] trace;
  logic                     pc_valid;
  pc_t                      pc;
  logic       [63:0]        cnt_rdata;

  // Reference model state
  pc_t         ref_q [NrPorts][$];
  int unsigned ref_ptr;
  logic [63:0] ref_cnt [4];
  vec_row_t    applied_row;
  integer      seed;
  int unsigned trace_errors, pc_errors, flag_errors, cnt_errors, timeouts;
  int unsigned wait_cycles;

  commit_trace_top UUT (
    .clk_i             ( clk             ),
    .rst_ni            ( rst_n           ),
    .commit_ack_i      ( commit_ack      ),
    .commit_pc_i       ( commit_pc       ),
    .commit_ex_valid_i ( commit_ex_valid ),
    .commit_cause_i    ( commit_cause    ),
    .commit_tval_i     ( commit_tval     ),
    .priv_lvl_i        ( priv_lvl        ),
    .debug_mode_i      ( debug_mode      ),
    .cnt_sel_i         ( cnt_sel         ),
    .cnt_we_i          ( cnt_we          ),
    .cnt_wdata_i       ( cnt_wdata       ),
    .trace_o           ( trace           ),
    .pc_valid_o        ( pc_valid        ),
    .pc_o              ( pc              ),
    .cnt_rdata_o       ( cnt_rdata       )
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  // --------------------
  // Compare tasks
  // --------------------
  task automatic check_trace(input int unsigned port, input trace_rec_t act,
                             input trace_rec_t exp);
    if (act !== exp) begin
      $display("mismatch trace_o[%0d]: got %h expected %h", port, act, exp);
      trace_errors++;
    end
  endtask

  task automatic check_pc(input pc_t act, input pc_t exp);
    if (act !== exp) begin
      $display("mismatch pc_o: got %h expected %h", act, exp);
      pc_errors++;
    end
  endtask

  task automatic check_valid(input string name, input logic act, input logic exp);
    if (act !== exp) begin
      $display("mismatch %s: got %h expected %h", name, act, exp);
      flag_errors++;
    end
  endtask

  task automatic check_cnt(input cnt_sel_t sel, input logic [63:0] act,
                           input logic [63:0] exp);
    if (act !== exp) begin
      $display("mismatch cnt_rdata_o (sel %h): got %h expected %h", sel, act, exp);
      cnt_errors++;
    end
  endtask

  function automatic logic [1:0] port_kind(input vec_row_t row, input int unsigned port);
    return (port == 0) ? row.kind0 : row.kind1;
  endfunction

  function automatic vec_row_t make_idle_row(input logic debug, input cnt_sel_t sel);
    vec_row_t row;
    row         = '0;
    row.priv    = PRIV_LVL_M;
    row.debug   = debug;
    row.cnt_sel = sel;
    return row;
  endfunction

  // Record as classified from the expected class of the commit
  function automatic trace_rec_t expected_record(input logic [1:0] kind, input pc_t pc_v,
                                                 input insn_t tval_v, input priv_lvl_t priv_v,
                                                 input cause_t cause_v);
    trace_rec_t rec;
    rec.valid     = (kind == KindRet);
    rec.iaddr     = pc_v;
    rec.insn      = tval_v;
    rec.priv      = priv_v;
    rec.exception = (kind == KindExc);
    rec.interrupt = (kind == KindIrq);
    rec.cause     = cause_v;
    rec.tval      = tval_v;
    return rec;
  endfunction

  task automatic drive_row(input vec_row_t row, input int unsigned idx);
    pc_t   pc_v;
    insn_t tval_v;
    for (int unsigned p = 0; p < NrPorts; p++) begin
      if (row.rand_pc) begin
        pc_v   = {$random(seed), $random(seed)};
        tval_v = $random(seed);
      end else begin
        pc_v   = 64'h8000_0000 + 64'(idx * 16 + p * 4);
        tval_v = 32'h0000_0013 + 32'(idx << 7) + 32'(p);
      end
      commit_pc[p]    <= pc_v;
      commit_tval[p]  <= tval_v;
      commit_cause[p] <= {row.irq[p], 63'(row.irq[p] ? 7 : (row.ex_valid[p] ? 2 : 0))};
    end
    commit_ack      <= row.ack;
    commit_ex_valid <= row.ex_valid;
    priv_lvl        <= row.priv;
    debug_mode      <= row.debug;
    cnt_we          <= row.cnt_we;
    cnt_sel         <= row.cnt_sel;
    cnt_wdata       <= 64'(row.cnt_wdata);
    applied_row = row;
  endtask

  // One clock: drive a row, then check what the last edge sampled
  task automatic step_cycle(input vec_row_t row, input int unsigned idx);
    vec_row_t    s_row;
    pc_t         s_pc [NrPorts];
    insn_t       s_tval [NrPorts];
    cause_t      s_cause [NrPorts];
    logic        granted;
    pc_t         exp_pc;
    int unsigned c;
    @(posedge clk);
    s_row = applied_row;
    for (int unsigned p = 0; p < NrPorts; p++) begin
      s_pc[p]    = commit_pc[p];
      s_tval[p]  = commit_tval[p];
      s_cause[p] = commit_cause[p];
    end
    drive_row(row, idx);
    @(negedge clk);
    for (int unsigned p = 0; p < NrPorts; p++) begin
      check_trace(p, trace[p], expected_record(port_kind(s_row, p), s_pc[p], s_tval[p],
                                               s_row.priv, s_cause[p]));
    end
    // Counter model
    if (!s_row.debug) begin
      ref_cnt[CNT_CYCLE] = ref_cnt[CNT_CYCLE] + 64'd1;
      for (int unsigned p = 0; p < NrPorts; p++) begin
        case (port_kind(s_row, p))
          KindRet: ref_cnt[CNT_INSTR] = ref_cnt[CNT_INSTR] + 64'd1;
          KindExc: ref_cnt[CNT_EXCEPTION] = ref_cnt[CNT_EXCEPTION] + 64'd1;
          KindIrq: ref_cnt[CNT_INTERRUPT] = ref_cnt[CNT_INTERRUPT] + 64'd1;
          KindNone: ;
        endcase
      end
    end
    if (s_row.cnt_we) begin
      ref_cnt[s_row.cnt_sel] = 64'(s_row.cnt_wdata);
    end
    // Retired PC queues and round-robin pick
    for (int unsigned p = 0; p < NrPorts; p++) begin
      if (port_kind(s_row, p) == KindRet) begin
        ref_q[p].push_back(s_pc[p]);
      end
    end
    granted = 1'b0;
    exp_pc  = '0;
    for (int unsigned i = 0; i < NrPorts; i++) begin
      c = (ref_ptr + i) % NrPorts;
      if (!granted && ref_q[c].size() != 0) begin
        granted = 1'b1;
        exp_pc  = ref_q[c].pop_front();
        ref_ptr = (c + 1) % NrPorts;
      end
    end
    check_valid("pc_valid_o", pc_valid, granted);
    if (granted && pc_valid) begin
      check_pc(pc, exp_pc);
    end
    check_cnt(applied_row.cnt_sel, cnt_rdata, ref_cnt[applied_row.cnt_sel]);
  endtask

  initial begin
    seed         = 32'hbb5d607e;
    trace_errors = 0;
    pc_errors    = 0;
    flag_errors  = 0;
    cnt_errors   = 0;
    timeouts     = 0;
    ref_ptr      = 0;
    for (int unsigned i = 0; i < 4; i++) begin
      ref_cnt[i] = '0;
    end
    rst_n           = 1'b0;
    commit_ack      = '0;
    commit_pc       = '0;
    commit_ex_valid = '0;
    commit_cause    = '0;
    commit_tval     = '0;
    priv_lvl        = PRIV_LVL_M;
    // Debug held so the counters stay at zero while they are read out
    debug_mode      = 1'b1;
    cnt_sel         = CNT_CYCLE;
    cnt_we          = 1'b0;
    cnt_wdata       = '0;
    applied_row     = make_idle_row(1'b1, CNT_CYCLE);

    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    for (int unsigned p = 0; p < NrPorts; p++) begin
      check_valid($sformatf("trace_o[%0d].valid", p), trace[p].valid, 1'b0);
      check_valid($sformatf("trace_o[%0d].exception", p), trace[p].exception, 1'b0);
      check_valid($sformatf("trace_o[%0d].interrupt", p), trace[p].interrupt, 1'b0);
    end
    check_valid("pc_valid_o", pc_valid, 1'b0);
    check_cnt(CNT_CYCLE, cnt_rdata, 64'd0);

    for (int unsigned k = 0; k < NumRows; k++) begin
      step_cycle(Vectors[k], k);
    end

    // Drain the retired PC stream
    wait_cycles = 0;
    while ((pc_valid || ref_q[0].size() != 0 || ref_q[1].size() != 0) &&
           wait_cycles < DrainTimeout) begin
      step_cycle(make_idle_row(1'b0, CNT_CYCLE), 0);
      wait_cycles++;
    end
    if (pc_valid || ref_q[0].size() != 0 || ref_q[1].size() != 0) begin
      $display("Timed out waiting for the retired PC stream to drain");
      timeouts++;
    end

    // Final totals, counters held
    for (int unsigned s = 0; s < 4; s++) begin
      step_cycle(make_idle_row(1'b1, cnt_sel_t'(s)), 0);
    end
    step_cycle(make_idle_row(1'b1, CNT_CYCLE), 0);

    $display("Errors: trace %0d, pc %0d, flag %0d, counter %0d, timeout %0d",
             trace_errors, pc_errors, flag_errors, cnt_errors, timeouts);
    if (trace_errors + pc_errors + flag_errors + cnt_errors + timeouts == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
+incdir+include
source/commit_trace_pkg.sv
source/trace_port_reg.sv
source/pc_fifo.sv
source/rr_arbiter.sv
source/retire_counters.sv
source/commit_trace_top.sv
verification/commit_trace_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the commit trace testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sim.f --top-module commit_trace_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vcommit_trace_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with an error"
  exit 1
fi

if printf '%s\n' "$out" | grep -q "^TESTS PASSED$"; then
  exit 0
fi
exit 1
